// File: source/bridge_consts.svh
`ifndef BRIDGE_CONSTS_SVH
`define BRIDGE_CONSTS_SVH

// byte address width.
`define ADDR_W 32

// one AXI data beat.
`define WORD_W 32

// one cache line, four beats.
`define LINE_W 128
`define LINE_BEATS 4

// one strobe bit per byte lane.
`define STRB_W 4

// low address bits cleared to align a line.
`define LINE_OFS_W 4

`endif

// File: source/axiPkg.sv
`default_nettype none
`include "bridge_consts.svh"

package axiPkg;

    typedef logic [`ADDR_W-1:0] addrT;
    typedef logic [`WORD_W-1:0] wordT;
    typedef logic [`STRB_W-1:0] strbT;

    // burst length minus one, as on the AXI bus.
    typedef logic [3:0] lenT;

    typedef logic [$clog2(`LINE_BEATS)-1:0] beatCntT;

endpackage

`default_nettype wire

// File: source/reqPkg.sv
`default_nettype none
`include "bridge_consts.svh"

package reqPkg;

    import axiPkg::*;

    typedef logic [`LINE_W-1:0] lineT;  // word 0 sits in the low bits.

    typedef struct packed {
        addrT pc;
    } instReqT;

    typedef struct packed {
        addrT addr;
        wordT data;
        strbT strobe;
        logic writeEn;
    } dataReqT;

endpackage

`default_nettype wire

// File: source/bridgeIfs.sv
`timescale 1ns/1ps
`default_nettype none

interface readRouteIf;

    logic active;     // read burst in data phase.
    logic toInst;     // line fill, else single word.
    logic lineDone;   // response taken by the client.
    logic rReadyOut;

    modport control (
        output active,
        output toInst,
        input  lineDone
    );

    modport assembler (
        input  active,
        input  toInst,
        output lineDone,
        output rReadyOut
    );

endinterface

interface writeBeatIf;

    import axiPkg::*;

    logic start;
    wordT data;
    strbT strobe;
    logic done;

    modport control (output start, output data, output strobe, input done);
    modport beat (input start, input data, input strobe, output done);

endinterface

`default_nettype wire

// File: source/reqSlot.sv
`timescale 1ns/1ps
`default_nettype none

module reqSlot #(
    parameter type payloadT = logic
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    reqValid,
    output logic    reqReady,
    input  payloadT reqPayload,
    output logic    busy,
    output payloadT held,
    input  logic    releaseSlot
);

    logic accept;

    assign reqReady = !busy;
    assign accept   = reqValid && reqReady;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
        end else if (accept) begin
            busy <= 1'b1;
        end else if (releaseSlot) begin
            busy <= 1'b0;  // ready again next cycle.
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            held <= reqPayload;
        end
    end

endmodule

`default_nettype wire

// File: source/busControl.sv
`timescale 1ns/1ps
`default_nettype none
`include "bridge_consts.svh"

module busControl (
    input  logic            clk,
    input  logic            rst,

    input  logic            instBusy,
    input  reqPkg::instReqT instHeld,
    output logic            instRelease,
    input  logic            dataBusy,
    input  reqPkg::dataReqT dataHeld,
    output logic            dataRelease,

    output logic            arValid,
    output axiPkg::addrT    arAddr,
    output axiPkg::lenT     arLen,
    input  logic            arReady,
    output logic            awValid,
    output axiPkg::addrT    awAddr,
    input  logic            awReady,

    readRouteIf.control     route,
    writeBeatIf.control     wr
);

    import axiPkg::*;

    localparam int wordOfsW = $clog2(`STRB_W);

    typedef enum logic [1:0] {
        rdIdle,
        rdAddr,
        rdData
    } rdStateT;

    typedef enum logic {
        wrIdle,
        wrBusy
    } wrStateT;

    rdStateT rdState;
    wrStateT wrState;

    logic dataRdPending;
    logic dataWrPending;
    logic selInst;
    logic arSel;
    logic readToInst;
    addrT lineAddr;
    addrT wordAddr;

    assign dataRdPending = dataBusy && !dataHeld.writeEn;
    assign dataWrPending = dataBusy && dataHeld.writeEn;
    assign selInst       = !dataRdPending;  // data reads win.

    assign lineAddr = {instHeld.pc[`ADDR_W-1:`LINE_OFS_W], {`LINE_OFS_W{1'b0}}};
    assign wordAddr = {dataHeld.addr[`ADDR_W-1:wordOfsW], {wordOfsW{1'b0}}};

    // choice is live in idle and locked once the address is offered.
    assign arSel   = (rdState == rdIdle) ? selInst : readToInst;
    assign arValid = (rdState == rdIdle) ? (dataRdPending || instBusy) : (rdState == rdAddr);
    assign arAddr  = arSel ? lineAddr : wordAddr;
    assign arLen   = arSel ? lenT'(`LINE_BEATS - 1) : lenT'(0);

    assign route.active = (rdState == rdData);
    assign route.toInst = readToInst;

    always_ff @(posedge clk) begin
        if (rst) begin
            rdState    <= rdIdle;
            readToInst <= 1'b0;
        end else begin
            case (rdState)
                rdIdle: begin
                    if (arValid) begin
                        readToInst <= selInst;
                        rdState    <= arReady ? rdData : rdAddr;
                    end
                end
                rdAddr: begin
                    if (arReady) begin
                        rdState <= rdData;
                    end
                end
                rdData: begin
                    if (route.lineDone) begin
                        rdState <= rdIdle;
                    end
                end
                default: rdState <= rdIdle;
            endcase
        end
    end

    assign awValid   = (wrState == wrIdle) && dataWrPending;
    assign awAddr    = wordAddr;
    assign wr.start  = awValid && awReady;  // beat goes out next cycle.
    assign wr.data   = dataHeld.data;
    assign wr.strobe = dataHeld.strobe;

    always_ff @(posedge clk) begin
        if (rst) begin
            wrState <= wrIdle;
        end else begin
            case (wrState)
                wrIdle: begin
                    if (wr.start) begin
                        wrState <= wrBusy;
                    end
                end
                wrBusy: begin
                    if (wr.done) begin
                        wrState <= wrIdle;
                    end
                end
                default: wrState <= wrIdle;
            endcase
        end
    end

    assign instRelease = route.lineDone && readToInst;
    assign dataRelease = (route.lineDone && !readToInst) || wr.done;

endmodule

`default_nettype wire

// File: source/lineAssembler.sv
`timescale 1ns/1ps
`default_nettype none
`include "bridge_consts.svh"

module lineAssembler (
    input  logic             clk,
    input  logic             rst,
    input  logic             rValid,
    input  axiPkg::wordT     rData,
    input  logic             rLast,
    readRouteIf.assembler    route,
    output logic             instRespValid,
    output reqPkg::lineT     instLine,
    input  logic             instRespReady,
    output logic             dataRespValid,
    output axiPkg::wordT     dataRdata,
    input  logic             dataRespReady
);

    import axiPkg::*;

    beatCntT beatCnt;
    logic    beatTaken;
    logic    instTaken;
    logic    dataTaken;

    // stall the bus while a response waits for the client.
    assign route.rReadyOut = route.active && !instRespValid && !dataRespValid;
    assign beatTaken       = rValid && route.rReadyOut;
    assign instTaken       = instRespValid && instRespReady;
    assign dataTaken       = dataRespValid && dataRespReady;
    assign route.lineDone  = instTaken || dataTaken;

    always_ff @(posedge clk) begin
        if (rst) begin
            beatCnt <= '0;
        end else if (!route.active) begin
            beatCnt <= '0;
        end else if (beatTaken) begin
            beatCnt <= beatCnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            instRespValid <= 1'b0;
            dataRespValid <= 1'b0;
        end else begin
            if (beatTaken && route.toInst && rLast) begin
                instRespValid <= 1'b1;
            end else if (instTaken) begin
                instRespValid <= 1'b0;
            end
            if (beatTaken && !route.toInst) begin
                dataRespValid <= 1'b1;  // single beat, no need to wait for last.
            end else if (dataTaken) begin
                dataRespValid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (beatTaken) begin
            if (route.toInst) begin
                instLine[beatCnt*`WORD_W +: `WORD_W] <= rData;
            end else begin
                dataRdata <= rData;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/writeBeat.sv
`timescale 1ns/1ps
`default_nettype none

module writeBeat (
    input  logic         clk,
    input  logic         rst,
    writeBeatIf.beat     wr,
    output logic         wValid,
    output axiPkg::wordT wData,
    output axiPkg::strbT wStrb,
    output logic         wLast,
    input  logic         wReady,
    input  logic         bValid,
    output logic         bReady
);

    logic wTaken;

    assign wTaken  = wValid && wReady;
    assign wLast   = 1'b1;  // every write is a one-beat burst.
    assign wr.done = bValid && bReady;

    always_ff @(posedge clk) begin
        if (rst) begin
            wValid <= 1'b0;
            bReady <= 1'b0;
        end else begin
            if (wr.start) begin
                wValid <= 1'b1;
            end else if (wTaken) begin
                wValid <= 1'b0;
            end
            if (wTaken) begin
                bReady <= 1'b1;
            end else if (wr.done) begin
                bReady <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr.start) begin
            wData <= wr.data;
            wStrb <= wr.strobe;
        end
    end

endmodule

`default_nettype wire

// File: source/axiBridge.sv
`timescale 1ns/1ps
`default_nettype none

module axiBridge (
    input  logic         clk,
    input  logic         rst,

    input  logic         instReqValid,
    input  axiPkg::addrT instPc,
    output logic         instReqReady,
    output logic         instRespValid,
    output reqPkg::lineT instLine,
    input  logic         instRespReady,

    input  logic         dataReqValid,
    input  axiPkg::addrT dataAddr,
    input  axiPkg::wordT dataWdata,
    input  axiPkg::strbT dataStrobe,
    input  logic         dataWriteEn,
    output logic         dataReqReady,
    output logic         dataRespValid,
    output axiPkg::wordT dataRdata,
    input  logic         dataRespReady,

    output logic         arValid,
    output axiPkg::addrT arAddr,
    output axiPkg::lenT  arLen,
    input  logic         arReady,
    input  logic         rValid,
    input  axiPkg::wordT rData,
    input  logic         rLast,
    output logic         rReady,
    output logic         awValid,
    output axiPkg::addrT awAddr,
    input  logic         awReady,
    output logic         wValid,
    output axiPkg::wordT wData,
    output axiPkg::strbT wStrb,
    output logic         wLast,
    input  logic         wReady,
    input  logic         bValid,
    output logic         bReady
);

    import reqPkg::*;

    instReqT instPayload;
    instReqT instHeld;
    dataReqT dataPayload;
    dataReqT dataHeld;
    logic    instBusy;
    logic    instRelease;
    logic    dataBusy;
    logic    dataRelease;

    readRouteIf route ();
    writeBeatIf wr ();

    assign instPayload = '{pc: instPc};
    assign dataPayload = '{addr: dataAddr, data: dataWdata, strobe: dataStrobe,
                           writeEn: dataWriteEn};
    assign rReady      = route.rReadyOut;

    reqSlot #(.payloadT(instReqT)) instSlot (
        .clk(clk), .rst(rst),
        .reqValid(instReqValid), .reqReady(instReqReady), .reqPayload(instPayload),
        .busy(instBusy), .held(instHeld), .releaseSlot(instRelease)
    );

    reqSlot #(.payloadT(dataReqT)) dataSlot (
        .clk(clk), .rst(rst),
        .reqValid(dataReqValid), .reqReady(dataReqReady), .reqPayload(dataPayload),
        .busy(dataBusy), .held(dataHeld), .releaseSlot(dataRelease)
    );

    busControl busCtrl (
        .clk(clk), .rst(rst),
        .instBusy(instBusy), .instHeld(instHeld), .instRelease(instRelease),
        .dataBusy(dataBusy), .dataHeld(dataHeld), .dataRelease(dataRelease),
        .arValid(arValid), .arAddr(arAddr), .arLen(arLen), .arReady(arReady),
        .awValid(awValid), .awAddr(awAddr), .awReady(awReady),
        .route(route.control), .wr(wr.control)
    );

    lineAssembler lineAsm (
        .clk(clk), .rst(rst),
        .rValid(rValid), .rData(rData), .rLast(rLast), .route(route.assembler),
        .instRespValid(instRespValid), .instLine(instLine), .instRespReady(instRespReady),
        .dataRespValid(dataRespValid), .dataRdata(dataRdata), .dataRespReady(dataRespReady)
    );

    writeBeat wrBeat (
        .clk(clk), .rst(rst), .wr(wr.beat),
        .wValid(wValid), .wData(wData), .wStrb(wStrb), .wLast(wLast), .wReady(wReady),
        .bValid(bValid), .bReady(bReady)
    );

endmodule

`default_nettype wire

// File: tb/axiMemModel.sv
`timescale 1ns/1ps
`default_nettype none

module axiMemModel #(
    parameter logic [31:0] initPattern = 32'h0,
    parameter logic [31:0] seedInit    = 32'h1
) (
    input  logic         clk,
    input  logic         rst,
    input  logic         arValid,
    input  axiPkg::addrT arAddr,
    input  axiPkg::lenT  arLen,
    output logic         arReady,
    output logic         rValid,
    output axiPkg::wordT rData,
    output logic         rLast,
    input  logic         rReady,
    input  logic         awValid,
    input  axiPkg::addrT awAddr,
    output logic         awReady,
    input  logic         wValid,
    input  axiPkg::wordT wData,
    input  axiPkg::strbT wStrb,
    output logic         wReady,
    output logic         bValid,
    input  logic         bReady
);

    import axiPkg::*;

    wordT   mem [addrT];
    integer seed;
    wordT   rnd;
    logic   arFire, rFire, awFire, wFire, bFire;
    logic   rdActive, bPending;
    addrT   arAddrQ, awAddrQ, rdAddr, wrAddr;
    lenT    arLenQ, rdLeft;
    wordT   wDataQ;
    strbT   wStrbQ;

    function automatic wordT readWord(input addrT a);
        addrT w;
        w = {a[31:2], 2'b00};
        if (mem.exists(w)) begin
            return mem[w];
        end
        return w ^ initPattern;  // untouched words follow the fill pattern.
    endfunction

    function automatic wordT mergeBytes(input wordT old, input wordT data, input strbT strb);
        wordT res;
        int   i;
        res = old;
        for (i = 0; i < 4; i++) begin
            if (strb[i]) begin
                res[i*8 +: 8] = data[i*8 +: 8];
            end
        end
        return res;
    endfunction

    // outputs change on the falling edge, transfers are seen just after it.
    initial begin
        seed = seedInit;
        {arReady, rValid, rLast, awReady, wReady, bValid} = '0;
        {arFire, rFire, awFire, wFire, bFire} = '0;
        {rdActive, bPending} = '0;
        rData  = '0;
        rdAddr = '0;
        rdLeft = '0;
        wrAddr = '0;
        forever begin
            @(negedge clk);
            if (rst) begin
                {arReady, rValid, rLast, awReady, wReady, bValid} = '0;
                {rdActive, bPending} = '0;
            end else begin
                if (arFire) begin
                    rdActive = 1'b1;
                    rdAddr   = arAddrQ;
                    rdLeft   = arLenQ;
                end
                if (rFire) begin
                    if (rLast) begin
                        rdActive = 1'b0;
                    end else begin
                        rdAddr = rdAddr + 32'd4;
                        rdLeft = rdLeft - 1'b1;
                    end
                end
                if (awFire) begin
                    wrAddr = awAddrQ;
                end
                if (wFire) begin
                    mem[{wrAddr[31:2], 2'b00}] = mergeBytes(readWord(wrAddr), wDataQ, wStrbQ);
                    bPending = 1'b1;
                end
                if (bFire) begin
                    bPending = 1'b0;
                end
                rnd     = $random(seed);
                arReady = !rdActive && (rnd[1:0] != 2'b00);
                if (!rValid || rFire) begin
                    rValid = rdActive && rnd[2];  // a raised valid waits for its transfer.
                end
                rData   = readWord(rdAddr);
                rLast   = (rdLeft == 4'd0);
                awReady = rnd[3] || rnd[4];
                wReady  = rnd[5] || rnd[6];
                if (!bValid || bFire) begin
                    bValid = bPending && rnd[7];
                end
            end
            #1;
            arFire  = arValid && arReady;
            rFire   = rValid && rReady;
            awFire  = awValid && awReady;
            wFire   = wValid && wReady;
            bFire   = bValid && bReady;
            arAddrQ = arAddr;
            arLenQ  = arLen;
            awAddrQ = awAddr;
            wDataQ  = wData;
            wStrbQ  = wStrb;
        end
    end

endmodule

`default_nettype wire

// File: tb/tbBridge.sv
`timescale 1ns/1ps
`default_nettype none

module tbBridge;

    import axiPkg::*;
    import reqPkg::*;

    localparam int          numOps     = 52;  // requests issued over all phases.
    localparam int          cycleLimit = 200 * numOps;
    localparam logic [31:0] seedInit   = 32'h5275_851b;
    localparam logic [31:0] memPattern = 32'h3c5a_96e1;

    logic clk;
    logic rst;
    logic instReqValid, instReqReady, instRespValid, instRespReady;
    addrT instPc;
    lineT instLine;
    logic dataReqValid, dataWriteEn, dataReqReady, dataRespValid, dataRespReady;
    addrT dataAddr;
    wordT dataWdata, dataRdata;
    strbT dataStrobe;
    logic arValid, arReady, rValid, rLast, rReady;
    logic awValid, awReady, wValid, wLast, wReady, bValid, bReady;
    addrT arAddr, awAddr;
    lenT  arLen;
    wordT rData, wData;
    strbT wStrb;

    integer seed      = seedInit;
    integer readySeed = seedInit + 1;
    wordT   readyRnd;
    logic   bpOn      = 1'b0;
    int     cycles    = 0;

    wordT shadow [addrT];  // words changed by writes so far.
    lineT instExpQ [$];
    wordT dataExpQ [$];
    lineT instExp, instLast;
    wordT dataExp, dataLast;
    logic instWaiting = 1'b0;
    logic dataWaiting = 1'b0;

    axiBridge i_dut (.*);

    axiMemModel #(.initPattern(memPattern), .seedInit(seedInit)) memModel (.*);

    function automatic wordT memInit(input addrT a);
        return {a[31:2], 2'b00} ^ memPattern;
    endfunction

    function automatic wordT shadowWord(input addrT a);
        addrT w;
        w = {a[31:2], 2'b00};
        if (shadow.exists(w)) begin
            return shadow[w];
        end
        return memInit(w);
    endfunction

    function automatic wordT mergeBytes(input wordT old, input wordT data, input strbT strb);
        wordT res;
        int   i;
        res = old;
        for (i = 0; i < 4; i++) begin
            if (strb[i]) begin
                res[i*8 +: 8] = data[i*8 +: 8];
            end
        end
        return res;
    endfunction

    // word k of the line sits at base + 4k and word 0 in the low bits.
    function automatic lineT expectLine(input addrT pc);
        lineT line;
        addrT base;
        int   k;
        base = {pc[31:4], 4'h0};
        for (k = 0; k < 4; k++) begin
            line[k*32 +: 32] = shadowWord(base + 32'(4 * k));
        end
        return line;
    endfunction

    task automatic stopWithError(input string msg);
        $display("%s", msg);
        $display("Checks failed");
        $fatal(1, "stopping at the first error");
    endtask

    // entered and left on a falling edge.
    task automatic fetchLine(input addrT pc);
        instReqValid = 1'b1;
        instPc       = pc;
        #1;
        while (!instReqReady) begin
            @(negedge clk);
            #1;
        end
        instExpQ.push_back(expectLine(pc));
        @(negedge clk);
        instReqValid = 1'b0;
    endtask

    task automatic dataAccess(input addrT addr, input wordT wdata, input strbT strb,
                              input logic we);
        dataReqValid = 1'b1;
        dataAddr     = addr;
        dataWdata    = wdata;
        dataStrobe   = strb;
        dataWriteEn  = we;
        #1;
        while (!dataReqReady) begin
            @(negedge clk);
            #1;
        end
        if (we) begin
            shadow[{addr[31:2], 2'b00}] = mergeBytes(shadowWord(addr), wdata, strb);
        end else begin
            dataExpQ.push_back(shadowWord(addr));
        end
        @(negedge clk);
        dataReqValid = 1'b0;
    endtask

    task automatic waitIdle();
        #1;
        while (instExpQ.size() != 0 || dataExpQ.size() != 0 || !instReqReady || !dataReqReady) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        instRespReady = 1'b1;
        dataRespReady = 1'b1;
        forever begin
            @(negedge clk);
            readyRnd      = $random(readySeed);
            instRespReady = !bpOn || (readyRnd[1:0] == 2'b00);  // mostly low under back-pressure.
            dataRespReady = !bpOn || (readyRnd[3:2] == 2'b00);
        end
    end

    always @(posedge clk) begin
        cycles++;
        assert (cycles < cycleLimit)
            else stopWithError($sformatf("Simulation timed out after %0d cycles", cycles));
    end

    always @(negedge clk) begin
        #1;
        if (!rst) begin
            assert (instRespValid || !instWaiting)
                else stopWithError("Instruction response dropped before the client took it");
            assert (!instWaiting || instLine == instLast)
                else stopWithError($sformatf("Fail instLine held %h changed to %h",
                                             instLast, instLine));
            if (instRespValid && instRespReady) begin
                assert (instExpQ.size() > 0)
                    else stopWithError("Instruction response arrived with no fetch outstanding");
                instExp = instExpQ.pop_front();
                assert (instLine == instExp)
                    else stopWithError($sformatf("Fail instLine expected %h got %h",
                                                 instExp, instLine));
            end
            instWaiting = instRespValid && !instRespReady;
            instLast    = instLine;

            assert (dataRespValid || !dataWaiting)
                else stopWithError("Data response dropped before the client took it");
            assert (!dataWaiting || dataRdata == dataLast)
                else stopWithError($sformatf("Fail dataRdata held %h changed to %h",
                                             dataLast, dataRdata));
            if (dataRespValid && dataRespReady) begin
                assert (dataExpQ.size() > 0)
                    else stopWithError("Data response arrived with no read outstanding");
                dataExp = dataExpQ.pop_front();
                assert (dataRdata == dataExp)
                    else stopWithError($sformatf("Fail dataRdata expected %h got %h",
                                                 dataExp, dataRdata));
            end
            dataWaiting = dataRespValid && !dataRespReady;
            dataLast    = dataRdata;

            assert (!wValid || wLast)
                else stopWithError("Write beat was offered without wLast set");
        end
    end

    initial begin
        int   i;
        int   j;
        int   k;
        addrT addr;
        wordT wrData;
        wordT wrStrb;

        rst          = 1'b1;
        instReqValid = 1'b0;
        instPc       = '0;
        dataReqValid = 1'b0;
        dataAddr     = '0;
        dataWdata    = '0;
        dataStrobe   = '0;
        dataWriteEn  = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        #1;
        assert (!arValid && !awValid && !wValid && !bReady && !rReady
                && !instRespValid && !dataRespValid)
            else stopWithError("A valid, rReady or bReady output is high after reset");
        assert (instReqReady && dataReqReady)
            else stopWithError("A request ready is low after reset");
        @(negedge clk);

        for (i = 0; i < 4; i++) begin
            fetchLine(32'h0000_1006 + 32'h44 * i);  // unaligned pc.
        end
        waitIdle();

        for (i = 0; i < 4; i++) begin
            dataAccess(32'h0000_8002 + 32'hc * i, '0, '0, 1'b0);
        end
        waitIdle();

        for (i = 0; i < 4; i++) begin
            addr   = 32'h0000_8100 + 32'(4 * i);
            wrData = $random(seed);
            wrStrb = $random(seed);
            dataAccess(addr, wrData, wrStrb[3:0], 1'b1);
            dataAccess(addr + 32'd1, '0, '0, 1'b0);
        end
        waitIdle();

        // fills and writes in parallel on separate address ranges.
        fork
            for (j = 0; j < 8; j++) begin
                fetchLine(32'h0000_1803 + 32'h10 * j);
            end
            for (k = 0; k < 8; k++) begin
                wrData = $random(seed);
                wrStrb = $random(seed);
                dataAccess(32'h0000_8200 + 32'(4 * k), wrData, wrStrb[3:0], 1'b1);
            end
        join
        waitIdle();
        for (i = 0; i < 8; i++) begin
            dataAccess(32'h0000_8200 + 32'(4 * i), '0, '0, 1'b0);
        end
        waitIdle();

        bpOn = 1'b1;
        fork
            for (j = 0; j < 6; j++) begin
                fetchLine(32'h0000_1c09 + 32'h20 * j);
            end
            for (k = 0; k < 6; k++) begin
                dataAccess(32'h0000_8200 + 32'(4 * k), '0, '0, 1'b0);
            end
        join
        waitIdle();
        bpOn = 1'b0;

        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
+incdir+source
source/axiPkg.sv
source/reqPkg.sv
source/bridgeIfs.sv
source/reqSlot.sv
source/busControl.sv
source/lineAssembler.sv
source/writeBeat.sv
source/axiBridge.sv
tb/axiMemModel.sv
tb/tbBridge.sv

// File: run.sh
#!/bin/sh
# builds the bridge testbench with Verilator, runs it and looks for the pass line.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module tbBridge

out="$(./obj_dir/VtbBridge 2>&1)" || true
printf '%s\n' "$out"

printf '%s\n' "$out" | grep "All checks passed" > /dev/null
